// ==== Makefile ====
# Verilator build and run for the resize command front end

VERILATOR ?= verilator
TOP       ?= tb_resize_dma_cmd
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== project.f ====
verilog/resize_dma_pkg.sv
verilog/resize_req_ctrl.sv
verilog/row_fetch_cmd_gen.sv
verilog/row_store_cmd_gen.sv
verilog/resize_dma_cmd_top.sv
test/resize_dma_cmd_assertions.sv
test/tb_resize_dma_cmd.sv

// ==== test/resize_dma_cmd_assertions.sv ====
// output protocol checks for the command front end; reset check starts on the second reset cycle
module resize_dma_cmd_assertions (
	input logic                        clk,
	input logic                        resetn,
	input logic                        s_req_ready,
	input resize_dma_pkg::resize_req_t m_req,
	input logic                        m_req_valid,
	input logic                        m_req_ready,
	input resize_dma_pkg::dma_cmd_t    m_rd_cmd,
	input logic                        m_rd_cmd_valid,
	input logic                        m_rd_cmd_ready,
	input resize_dma_pkg::dma_cmd_t    m_wr_cmd,
	input logic                        m_wr_cmd_valid,
	input logic                        m_wr_cmd_ready
);
	int assert_errs = 0; // failure count, read by the testbench

	// valid and payload frozen while stalled
	req_hold: assert property (@(posedge clk) disable iff (!resetn)
		m_req_valid && !m_req_ready |=> m_req_valid && $stable(m_req))
		else
		begin
			$error("forwarded request dropped or changed under a stall");
			assert_errs++;
		end
	rd_hold: assert property (@(posedge clk) disable iff (!resetn)
		m_rd_cmd_valid && !m_rd_cmd_ready |=> m_rd_cmd_valid && $stable(m_rd_cmd))
		else
		begin
			$error("read command dropped or changed under a stall");
			assert_errs++;
		end
	wr_hold: assert property (@(posedge clk) disable iff (!resetn)
		m_wr_cmd_valid && !m_wr_cmd_ready |=> m_wr_cmd_valid && $stable(m_wr_cmd))
		else
		begin
			$error("write command dropped or changed under a stall");
			assert_errs++;
		end

	reset_quiet: assert property (@(posedge clk) !resetn && $past(!resetn) |->
		!m_req_valid && !m_rd_cmd_valid && !m_wr_cmd_valid && !s_req_ready)
		else
		begin
			$error("valid or ready high during reset");
			assert_errs++;
		end

	// idle means both generators drained
	idle_no_cmd: assert property (@(posedge clk) disable iff (!resetn)
		s_req_ready |-> !m_rd_cmd_valid && !m_wr_cmd_valid)
		else
		begin
			$error("request side ready with commands pending");
			assert_errs++;
		end

endmodule

bind resize_dma_cmd_top resize_dma_cmd_assertions u_assertions (
	.clk            (clk),
	.resetn         (resetn),
	.s_req_ready    (s_req_ready),
	.m_req          (m_req),
	.m_req_valid    (m_req_valid),
	.m_req_ready    (m_req_ready),
	.m_rd_cmd       (m_rd_cmd),
	.m_rd_cmd_valid (m_rd_cmd_valid),
	.m_rd_cmd_ready (m_rd_cmd_ready),
	.m_wr_cmd       (m_wr_cmd),
	.m_wr_cmd_valid (m_wr_cmd_valid),
	.m_wr_cmd_ready (m_wr_cmd_ready)
);

// ==== test/tb_resize_dma_cmd.sv ====
// directed tests only; reference model follows the row rules, stalls from a galois lfsr, cycle budget ends a hang
module tb_resize_dma_cmd;
	import resize_dma_pkg::*;

	logic        clk = 1'b0;
	logic        resetn;
	resize_req_t s_req;
	logic        s_req_valid;
	logic        s_req_ready;
	resize_req_t m_req;
	logic        m_req_valid;
	logic        m_req_ready;
	dma_cmd_t    m_rd_cmd;
	logic        m_rd_cmd_valid;
	logic        m_rd_cmd_ready = 1'b0; // owned by the stall driver
	dma_cmd_t    m_wr_cmd;
	logic        m_wr_cmd_valid;
	logic        m_wr_cmd_ready = 1'b0;
	logic        stall_en;

	resize_req_t exp_req [$]; // expected streams, popped as the DUT delivers
	dma_cmd_t    exp_rd [$];
	dma_cmd_t    exp_wr [$];
	logic [31:0] lfsr = 32'd74364;
	int          cycles = 0;
	int          cycle_limit = 200; // grows by 40 per expected command
	int          val_errs = 0;
	int          stream_errs = 0;
	int          seq_errs = 0;
	int          rd_seen = 0;

	resize_dma_cmd_top UUT (
		.clk            (clk),
		.resetn         (resetn),
		.s_req          (s_req),
		.s_req_valid    (s_req_valid),
		.s_req_ready    (s_req_ready),
		.m_req          (m_req),
		.m_req_valid    (m_req_valid),
		.m_req_ready    (m_req_ready),
		.m_rd_cmd       (m_rd_cmd),
		.m_rd_cmd_valid (m_rd_cmd_valid),
		.m_rd_cmd_ready (m_rd_cmd_ready),
		.m_wr_cmd       (m_wr_cmd),
		.m_wr_cmd_valid (m_wr_cmd_valid),
		.m_wr_cmd_ready (m_wr_cmd_ready)
	);

	always #4 clk = !clk; // period 8

	// galois form, taps 32 30 26 25
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	function automatic resize_req_t make_req(input logic [15:0] src_h_sub1, input logic [15:0] dst_h_sub1,
		input logic [15:0] scale_y, input logic [15:0] src_stride, input logic [15:0] dst_stride,
		input logic [15:0] res_stride, input logic [31:0] src_base, input logic [31:0] res_base);
		resize_req_t r;
		r            = '0;
		r.chn_sub1   = 2'd2; // three channels, not used for commands
		r.src_w_sub1 = 16'd127;
		r.dst_w_sub1 = 16'd63;
		r.scale_x    = 16'h0200;
		r.src_h_sub1 = src_h_sub1;
		r.dst_h_sub1 = dst_h_sub1;
		r.scale_y    = scale_y;
		r.src_stride = src_stride;
		r.dst_stride = dst_stride;
		r.res_stride = res_stride;
		r.src_base   = src_base;
		r.res_base   = res_base;
		return r;
	endfunction

	// reference: two source rows and one result row per destination row
	function automatic void build_expected(input resize_req_t r);
		logic [31:0] acc;
		logic [15:0] i;
		logic [15:0] i1;
		dma_cmd_t    c;
		for (int d = 0; d <= int'(r.dst_h_sub1); d++)
		begin
			acc = 32'(d) * 32'(r.scale_y);
			i   = 16'(acc >> SCALE_FRAC_BITS); // integer source row
			i1  = (i >= r.src_h_sub1) ? r.src_h_sub1 : i + 16'd1;
			c.len  = 24'(r.src_stride);
			c.addr = r.src_base + 32'(i) * 32'(r.src_stride);
			exp_rd.push_back(c);
			c.addr = r.src_base + 32'(i1) * 32'(r.src_stride);
			exp_rd.push_back(c);
			c.len  = 24'(r.dst_stride);
			c.addr = r.res_base + 32'(d) * 32'(r.res_stride);
			exp_wr.push_back(c);
		end
	endfunction

	task automatic check_value(input string what, input logic [215:0] got, input logic [215:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s mismatch: got %h expected %h", $time, what, got, exp);
			val_errs++;
		end
	endtask

	// one random bit per ready, or both open
	always @(posedge clk)
	begin
		if (stall_en)
		begin
			lfsr = lfsr_next(lfsr);
			m_rd_cmd_ready <= lfsr[0];
			lfsr = lfsr_next(lfsr);
			m_wr_cmd_ready <= lfsr[0];
		end
		else
		begin
			m_rd_cmd_ready <= 1'b1;
			m_wr_cmd_ready <= 1'b1;
		end
	end

	// stream monitor, samples pre-edge values
	always @(posedge clk)
	begin
		if (resetn)
		begin
			if (s_req_ready && exp_req.size() >= 2)
			begin
				$display("request side open while the forward queue holds two requests");
				stream_errs++;
			end
			if (s_req_valid && s_req_ready)
			begin
				if (exp_rd.size() != 0 || exp_wr.size() != 0)
				begin
					$display("request accepted before all commands of the previous one left");
					stream_errs++;
				end
				exp_req.push_back(s_req);
				build_expected(s_req);
				cycle_limit = cycle_limit + 120 * (int'(s_req.dst_h_sub1) + 1);
			end
			if (m_req_valid && m_req_ready)
			begin
				if (exp_req.size() == 0)
				begin
					$display("forwarded request appeared with none accepted");
					stream_errs++;
				end
				else
					check_value("forwarded request", m_req, exp_req.pop_front());
			end
			if (m_rd_cmd_valid && m_rd_cmd_ready)
			begin
				rd_seen++;
				if (exp_rd.size() == 0)
				begin
					$display("extra read command %h with none expected", m_rd_cmd);
					stream_errs++;
				end
				else
					check_value("read command", 216'(m_rd_cmd), 216'(exp_rd.pop_front()));
			end
			if (m_wr_cmd_valid && m_wr_cmd_ready)
			begin
				if (exp_wr.size() == 0)
				begin
					$display("extra write command %h with none expected", m_wr_cmd);
					stream_errs++;
				end
				else
					check_value("write command", 216'(m_wr_cmd), 216'(exp_wr.pop_front()));
			end
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
		begin
			$display("timeout after %0d cycles, DUT stopped making progress", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic send_req(input resize_req_t req);
		@(posedge clk);
		s_req       <= req;
		s_req_valid <= 1'b1;
		do
			@(posedge clk);
		while (!s_req_ready); // transfer on this edge
		s_req_valid <= 1'b0;
	endtask

	// controller back in idle, then nothing may still be owed
	task automatic finish_request();
		do
			@(posedge clk);
		while (!s_req_ready);
		@(negedge clk);
		if (exp_rd.size() != 0 || exp_wr.size() != 0 || exp_req.size() != 0)
		begin
			$display("missing output: %0d reads, %0d writes, %0d forwarded requests never came",
				exp_rd.size(), exp_wr.size(), exp_req.size());
			seq_errs++;
		end
	endtask

	task automatic idle_after_reset();
		int n;
		n = 0;
		@(posedge clk);
		if (s_req_ready)
		begin
			$display("[FAIL] %0t s_req_ready high in the first cycle after reset", $time);
			seq_errs++;
		end
		while (!s_req_ready && n < 4)
		begin
			@(posedge clk);
			n++;
		end
		if (!s_req_ready)
		begin
			$display("s_req_ready never rose after reset");
			seq_errs++;
		end
		if (m_req_valid || m_rd_cmd_valid || m_wr_cmd_valid)
		begin
			$display("[FAIL] %0t output valid high with no request", $time);
			seq_errs++;
		end
		repeat (20) @(posedge clk); // monitor flags any stray command
	endtask

	task automatic downscale_rows(); // 40 rows to 16, scale 2.5
		send_req(make_req(16'd39, 16'd15, 16'h0280, 16'd640, 16'd256, 16'd320,
			32'h1000_0000, 32'h2000_0040));
		finish_request();
	endtask

	task automatic upscale_clamp();
		int rd0;
		rd0 = rd_seen;
		// 8 rows to 20, last rows hit src_h_sub1
		send_req(make_req(16'd7, 16'd19, 16'h0067, 16'd96, 16'd240, 16'd256,
			32'h0004_0000, 32'h0008_0000));
		finish_request();
		if (rd_seen - rd0 != 40)
		begin
			$display("upscale gave %0d read commands instead of two per row", rd_seen - rd0);
			seq_errs++;
		end
	endtask

	task automatic stalled_sinks();
		stall_en <= 1'b1;
		send_req(make_req(16'd23, 16'd11, 16'h0200, 16'd512, 16'd128, 16'd192,
			32'h3000_0100, 32'h4000_0000));
		finish_request();
		stall_en <= 1'b0;
	endtask

	task automatic queued_requests();
		@(posedge clk);
		m_req_ready <= 1'b0; // interpolation engine not taking yet
		fork
			begin
				send_req(make_req(16'd5, 16'd3, 16'h0180, 16'd64, 16'd32, 16'd48,
					32'h5000_0000, 32'h6000_0000));
				send_req(make_req(16'd9, 16'd3, 16'h0280, 16'd80, 16'd40, 16'd64,
					32'h5100_0000, 32'h6100_0000));
				send_req(make_req(16'd3, 16'd3, 16'h0100, 16'd48, 16'd48, 16'd48,
					32'h5200_0000, 32'h6200_0000));
			end
			begin
				repeat (60) @(posedge clk);
				if (exp_req.size() != 2) // third one must still be waiting
				begin
					$display("forward queue holds %0d requests, two expected", exp_req.size());
					seq_errs++;
				end
				m_req_ready <= 1'b1;
			end
		join
		finish_request();
	endtask

	initial
	begin
		resetn      <= 1'b0;
		s_req       <= '0;
		s_req_valid <= 1'b0;
		m_req_ready <= 1'b1;
		stall_en    <= 1'b0;
		repeat (7) @(posedge clk);
		if (m_req_valid || m_rd_cmd_valid || m_wr_cmd_valid || s_req_ready)
		begin
			$display("[FAIL] %0t output valid or ready high during reset", $time);
			seq_errs++;
		end
		@(posedge clk);
		resetn <= 1'b1; // eighth cycle
		idle_after_reset();
		downscale_rows();
		upscale_clamp();
		stalled_sinks();
		queued_requests();
		$display("errors: %0d wrong values, %0d stream faults, %0d sequence faults, %0d assertions",
			val_errs, stream_errs, seq_errs, UUT.u_assertions.assert_errs);
		if (val_errs + stream_errs + seq_errs + UUT.u_assertions.assert_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== verilog/resize_dma_cmd_top.sv ====
// command front end of the resize accelerator; dma engines and interpolation sit outside, all streams valid/ready
module resize_dma_cmd_top (
	input  logic                        clk,
	input  logic                        resetn,
	input  resize_dma_pkg::resize_req_t s_req,
	input  logic                        s_req_valid,
	output logic                        s_req_ready,
	output resize_dma_pkg::resize_req_t m_req,
	output logic                        m_req_valid,
	input  logic                        m_req_ready,
	output resize_dma_pkg::dma_cmd_t    m_rd_cmd,
	output logic                        m_rd_cmd_valid,
	input  logic                        m_rd_cmd_ready,
	output resize_dma_pkg::dma_cmd_t    m_wr_cmd,
	output logic                        m_wr_cmd_valid,
	input  logic                        m_wr_cmd_ready
);
	import resize_dma_pkg::*;

	resize_req_t cfg;      // latched request
	logic        start;    // one-cycle kick
	logic        fin_clr;  // high in ctrl_done
	logic        fetch_fin;
	logic        store_fin;

	resize_req_ctrl u_ctrl (
		.clk         (clk),
		.resetn      (resetn),
		.s_req       (s_req),
		.s_req_valid (s_req_valid),
		.s_req_ready (s_req_ready),
		.m_req       (m_req),
		.m_req_valid (m_req_valid),
		.m_req_ready (m_req_ready),
		.cfg         (cfg),
		.start       (start),
		.fetch_fin   (fetch_fin),
		.store_fin   (store_fin),
		.fin_clr     (fin_clr)
	);

	// source-row reads, three-stage pipe
	row_fetch_cmd_gen u_fetch (
		.clk            (clk),
		.resetn         (resetn),
		.cfg            (cfg),
		.start          (start),
		.fin_clr        (fin_clr),
		.m_rd_cmd       (m_rd_cmd),
		.m_rd_cmd_valid (m_rd_cmd_valid),
		.m_rd_cmd_ready (m_rd_cmd_ready),
		.fetch_fin      (fetch_fin)
	);

	// result-row writes
	row_store_cmd_gen u_store (
		.clk            (clk),
		.resetn         (resetn),
		.cfg            (cfg),
		.start          (start),
		.fin_clr        (fin_clr),
		.m_wr_cmd       (m_wr_cmd),
		.m_wr_cmd_valid (m_wr_cmd_valid),
		.m_wr_cmd_ready (m_wr_cmd_ready),
		.store_fin      (store_fin)
	);

endmodule

// ==== verilog/resize_dma_pkg.sv ====
// shared types for the resize command front end; sizes are stored minus one, strides limit lengths to 16 bits
package resize_dma_pkg;

	// fraction bits of scale_y and of the row accumulator
	localparam int SCALE_FRAC_BITS = 8;
	// integer row part plus fraction
	localparam int ROW_ACC_WIDTH = 16 + SCALE_FRAC_BITS;

	// bilinear resize request, 216 bits, msb first
	typedef struct packed
	{
		logic [5:0]  reserved;
		logic [1:0]  chn_sub1;   // channels - 1, passed through only
		logic [15:0] src_w_sub1;
		logic [15:0] src_h_sub1; // clamp limit for i1
		logic [15:0] dst_w_sub1;
		logic [15:0] dst_h_sub1; // last destination row
		logic [15:0] scale_x;    // src_w / dst_w, unsigned fixed point
		logic [15:0] scale_y;    // src_h / dst_h, SCALE_FRAC_BITS fraction
		logic [15:0] src_stride; // bytes per source row
		logic [15:0] dst_stride; // bytes per result row, write length
		logic [15:0] res_stride; // row pitch of the result buffer
		logic [31:0] src_base;
		logic [31:0] res_base;
	} resize_req_t;

	// dma command, incrementing burst only
	typedef struct packed
	{
		logic [23:0] len;  // bytes to move
		logic [31:0] addr; // first byte
	} dma_cmd_t;

	// request controller sequencing
	typedef enum logic [1:0]
	{
		ctrl_idle,  // waiting for a request
		ctrl_start, // one cycle, kicks both generators
		ctrl_busy,  // until both finished flags set
		ctrl_done   // one cycle, clears the flags
	} ctrl_state_e;

endpackage

// ==== verilog/resize_req_ctrl.sv ====
// one request in flight; forward queue is two registers deep and s_req_ready stays low one cycle past reset
module resize_req_ctrl (
	input  logic                        clk,
	input  logic                        resetn,
	input  resize_dma_pkg::resize_req_t s_req,
	input  logic                        s_req_valid,
	output logic                        s_req_ready,
	output resize_dma_pkg::resize_req_t m_req,
	output logic                        m_req_valid,
	input  logic                        m_req_ready,
	output resize_dma_pkg::resize_req_t cfg,
	output logic                        start,
	input  logic                        fetch_fin,
	input  logic                        store_fin,
	output logic                        fin_clr
);
	import resize_dma_pkg::*;

	ctrl_state_e state;
	resize_req_t q_mem [0:1]; // forwarded copies for the interpolation engine
	logic        q_wr_ptr;
	logic        q_rd_ptr;
	logic [1:0]  q_cnt;      // 0..2 entries
	logic [1:0]  q_cnt_nxt;
	logic        q_space;    // registered not-full
	logic        q_wen;
	logic        q_ren;

	// accept only when idle and the copy has somewhere to go
	assign s_req_ready = (state == ctrl_idle) && q_space;
	assign q_wen       = s_req_valid && s_req_ready; // same cycle as acceptance
	assign q_ren       = m_req_valid && m_req_ready;

	assign m_req_valid = q_cnt != 2'd0; // registered count, so one cycle after first write
	assign m_req       = q_mem[q_rd_ptr];
	assign q_cnt_nxt   = q_cnt + {1'b0, q_wen} - {1'b0, q_ren};

	assign start   = state == ctrl_start;
	assign fin_clr = state == ctrl_done; // drop both finished flags

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			q_wr_ptr <= 1'b0;
			q_rd_ptr <= 1'b0;
			q_cnt    <= 2'd0;
			q_space  <= 1'b0; // held off until the first clock after reset
		end
		else
		begin
			if (q_wen)
				q_wr_ptr <= !q_wr_ptr;
			if (q_ren)
				q_rd_ptr <= !q_rd_ptr;
			q_cnt   <= q_cnt_nxt;
			q_space <= q_cnt_nxt != 2'd2;
		end
	end

	// queue storage
	always_ff @(posedge clk)
	begin
		if (q_wen)
			q_mem[q_wr_ptr] <= s_req;
	end

	// parameters for the generators, stable from start to done
	always_ff @(posedge clk)
	begin
		if (q_wen)
			cfg <= s_req;
	end

	// idle -> start -> busy -> done -> idle
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			state <= ctrl_idle;
		else
		begin
			case (state)
				ctrl_idle:
					if (q_wen)
						state <= ctrl_start;
				ctrl_start:
					state <= ctrl_busy;
				ctrl_busy:
					if (fetch_fin && store_fin) // both generators drained
						state <= ctrl_done;
				default:
					state <= ctrl_idle; // ctrl_done lasts one cycle
			endcase
		end
	end

endmodule

// ==== verilog/row_fetch_cmd_gen.sv ====
// two source-row reads per destination row; cfg must stay stable until fin_clr, row offsets wrap at 32 bits
module row_fetch_cmd_gen (
	input  logic                        clk,
	input  logic                        resetn,
	input  resize_dma_pkg::resize_req_t cfg,
	input  logic                        start,
	input  logic                        fin_clr,
	output resize_dma_pkg::dma_cmd_t    m_rd_cmd,
	output logic                        m_rd_cmd_valid,
	input  logic                        m_rd_cmd_ready,
	output logic                        fetch_fin
);
	import resize_dma_pkg::*;

	// stage 0, row selection
	logic                     s0_valid;
	logic                     s0_ready;
	logic                     s0_fire;
	logic                     sel_i1;   // 0 -> row i, 1 -> row i1
	logic [15:0]              dst_row;  // destination row d
	logic [ROW_ACC_WIDTH-1:0] row_acc;  // d * scale_y
	logic [15:0]              row_i;
	logic [15:0]              row_i1;   // captured while i goes out
	logic [15:0]              s0_row;
	logic [31:0]              s0_ofs;
	logic                     s0_last;  // i1 of the final row
	// stage 1, offset register
	logic                     s1_valid;
	logic                     s1_ready;
	logic [31:0]              s1_ofs;
	logic                     s1_last;
	// stage 2, output
	logic                     s2_valid;
	logic                     s2_last;
	dma_cmd_t                 s2_cmd;

	assign row_i   = row_acc[ROW_ACC_WIDTH-1:SCALE_FRAC_BITS]; // floor
	assign s0_row  = sel_i1 ? row_i1 : row_i;
	assign s0_ofs  = s0_row * cfg.src_stride; // 16 x 16 -> 32
	assign s0_last = sel_i1 && (dst_row == cfg.dst_h_sub1);

	// each stage moves when the next one is empty or moving
	assign s1_ready = !s2_valid || m_rd_cmd_ready;
	assign s0_ready = !s1_valid || s1_ready;
	assign s0_fire  = s0_valid && s0_ready;

	assign m_rd_cmd       = s2_cmd;
	assign m_rd_cmd_valid = s2_valid;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			s0_valid <= 1'b0;
		else if (start)
			s0_valid <= 1'b1;
		else if (s0_fire && s0_last) // all rows handed over
			s0_valid <= 1'b0;
	end

	// row counter, accumulator and i/i1 toggle
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			sel_i1  <= 1'b0;
			dst_row <= 16'd0;
			row_acc <= '0;
		end
		else if (start)
		begin
			sel_i1  <= 1'b0;
			dst_row <= 16'd0;
			row_acc <= '0;
		end
		else if (s0_fire)
		begin
			sel_i1 <= !sel_i1;
			if (sel_i1) // pair done, next destination row
			begin
				dst_row <= dst_row + 16'd1;
				row_acc <= row_acc + ROW_ACC_WIDTH'(cfg.scale_y);
			end
		end
	end

	// i1 clamps at the last source row
	always_ff @(posedge clk)
	begin
		if (s0_fire && !sel_i1)
			row_i1 <= (row_i >= cfg.src_h_sub1) ? cfg.src_h_sub1 : row_i + 16'd1;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end
		else
		begin
			if (s0_ready)
				s1_valid <= s0_valid;
			if (s1_ready)
				s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (s0_fire)
		begin
			s1_ofs  <= s0_ofs;
			s1_last <= s0_last;
		end
		if (s1_valid && s1_ready) // base add in the last stage
		begin
			s2_cmd  <= '{len: 24'(cfg.src_stride), addr: cfg.src_base + s1_ofs};
			s2_last <= s1_last;
		end
	end

	// set once the final read has left the output stage
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			fetch_fin <= 1'b0;
		else if (fin_clr)
			fetch_fin <= 1'b0;
		else if (s2_valid && m_rd_cmd_ready && s2_last)
			fetch_fin <= 1'b1;
	end

endmodule

// ==== verilog/row_store_cmd_gen.sv ====
// one result-row write per destination row; cfg must stay stable until fin_clr, addresses wrap at 32 bits
module row_store_cmd_gen (
	input  logic                        clk,
	input  logic                        resetn,
	input  resize_dma_pkg::resize_req_t cfg,
	input  logic                        start,
	input  logic                        fin_clr,
	output resize_dma_pkg::dma_cmd_t    m_wr_cmd,
	output logic                        m_wr_cmd_valid,
	input  logic                        m_wr_cmd_ready,
	output logic                        store_fin
);
	import resize_dma_pkg::*;

	logic [31:0] wr_addr;  // res_base + d * res_stride, kept as a running sum
	logic [15:0] dst_row;
	logic        wr_valid;
	logic        wr_fire;
	logic        wr_last;  // current row is dst_h_sub1

	assign wr_fire  = wr_valid && m_wr_cmd_ready;
	assign wr_last  = dst_row == cfg.dst_h_sub1;

	assign m_wr_cmd       = '{len: 24'(cfg.dst_stride), addr: wr_addr};
	assign m_wr_cmd_valid = wr_valid;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_valid <= 1'b0;
			dst_row  <= 16'd0;
		end
		else if (start)
		begin
			wr_valid <= 1'b1; // first command one cycle after start
			dst_row  <= 16'd0;
		end
		else if (wr_fire)
		begin
			dst_row <= dst_row + 16'd1;
			if (wr_last)
				wr_valid <= 1'b0;
		end
	end

	// address advances one result row per transfer
	always_ff @(posedge clk)
	begin
		if (start)
			wr_addr <= cfg.res_base;
		else if (wr_fire)
			wr_addr <= wr_addr + 32'(cfg.res_stride);
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			store_fin <= 1'b0;
		else if (fin_clr)
			store_fin <= 1'b0;
		else if (wr_fire && wr_last) // last row gone
			store_fin <= 1'b1;
	end

endmodule
